//--- mrp_tx_cfg.svh
`ifndef MRP_TX_CFG_SVH
`define MRP_TX_CFG_SVH

// NoC flit width in bits.
`define MRP_NOC_FLIT_W 64

// Width of one destination coordinate.
`define MRP_NOC_XY_W 8

// Width of a port number.
`define MRP_PORT_W 16

// Width of a byte or flit count.
`define MRP_LEN_W 16

// Message type carried in every header flit.
`define MRP_MSG_TYPE 8'h2a

`endif

//--- mrp_tx_pkg.sv
`include "mrp_tx_cfg.svh"

package mrp_tx_pkg;

    // One message descriptor from the engine.
    typedef struct packed {
        logic [`MRP_NOC_XY_W-1:0] dst_x;
        logic [`MRP_NOC_XY_W-1:0] dst_y;
        logic [`MRP_PORT_W-1:0]   src_port;
        logic [`MRP_PORT_W-1:0]   dst_port;
        logic [15:0]              conn_id;
        logic [`MRP_LEN_W-1:0]    payload_bytes;
        logic [31:0]              seq_num;
    } mrp_tx_meta;

    // NoC header view.
    typedef struct packed {
        logic [`MRP_NOC_XY_W-1:0] dst_x;
        logic [`MRP_NOC_XY_W-1:0] dst_y;
        logic [`MRP_LEN_W-1:0]    flit_count;
        logic [7:0]               msg_type;
        logic [`MRP_NOC_FLIT_W-2*`MRP_NOC_XY_W-`MRP_LEN_W-9:0] pad;
    } mrp_noc_hdr;

    // MRP metadata view.
    typedef struct packed {
        logic [`MRP_PORT_W-1:0]   src_port;
        logic [`MRP_PORT_W-1:0]   dst_port;
        logic [15:0]              conn_id;
        logic [`MRP_LEN_W-1:0]    payload_bytes;
    } mrp_meta_flit;

    typedef union packed {
        mrp_noc_hdr   hdr;
        mrp_meta_flit meta;
    } mrp_noc_flit;

    typedef enum logic [1:0] {
        SEL_HDR_FLIT  = 2'd0,
        SEL_META_FLIT = 2'd1,
        SEL_DATA_FLIT = 2'd2
    } mrp_noc_out_flit_mux_sel;

    // Packed payload flit with its end-of-message flag.
    typedef struct packed {
        logic                       last;
        logic [`MRP_NOC_FLIT_W-1:0] data;
    } mrp_data_beat;

endpackage

//--- mrp_tx_hdr_build.sv
`timescale 1ns/1ps
`include "mrp_tx_cfg.svh"

module mrp_tx_hdr_build (
    input  logic                    clk,
    input  logic                    rst,
    input  mrp_tx_pkg::mrp_tx_meta  meta,
    input  logic                    store_inputs,
    output mrp_tx_pkg::mrp_noc_flit hdr_flit,
    output mrp_tx_pkg::mrp_noc_flit meta_flit,
    output logic [`MRP_LEN_W-1:0]   payload_bytes
);

    localparam int LEN_W      = `MRP_LEN_W;
    localparam int FLIT_BYTES = `MRP_NOC_FLIT_W / 8;
    localparam int BYTE_IDX_W = $clog2(FLIT_BYTES);

    mrp_tx_pkg::mrp_meta_flit meta_reg;
    logic [LEN_W:0]           rounded_bytes;
    logic [LEN_W-1:0]         flit_count;

    // Round up to whole payload flits.
    assign rounded_bytes = {1'b0, meta.payload_bytes} + (LEN_W + 1)'(FLIT_BYTES - 1);

    // Metadata flit plus the payload flits.
    assign flit_count = LEN_W'(rounded_bytes >> BYTE_IDX_W) + LEN_W'(1);

    // Header goes out in the same cycle as meta_val.
    always_comb begin
        hdr_flit = '0;
        hdr_flit.hdr.dst_x      = meta.dst_x;
        hdr_flit.hdr.dst_y      = meta.dst_y;
        hdr_flit.hdr.flit_count = flit_count;
        hdr_flit.hdr.msg_type   = `MRP_MSG_TYPE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_reg <= '0;
        end else if (store_inputs) begin
            meta_reg.src_port      <= meta.src_port;
            meta_reg.dst_port      <= meta.dst_port;
            meta_reg.conn_id       <= meta.conn_id;
            meta_reg.payload_bytes <= meta.payload_bytes;
        end
    end

    // Later flits come from the stored copy.
    assign meta_flit.meta = meta_reg;
    assign payload_bytes  = meta_reg.payload_bytes;

endmodule

//--- mrp_tx_data_pack.sv
`timescale 1ns/1ps
`include "mrp_tx_cfg.svh"

module mrp_tx_data_pack (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`MRP_NOC_FLIT_W-1:0] data,
    input  logic                       beat_taken,
    input  logic [`MRP_LEN_W-1:0]      payload_bytes,
    output logic [`MRP_NOC_FLIT_W-1:0] data_flit,
    output logic                       last_output
);

    localparam int LEN_W      = `MRP_LEN_W;
    localparam int FLIT_BYTES = `MRP_NOC_FLIT_W / 8;
    localparam int BYTE_IDX_W = $clog2(FLIT_BYTES);
    localparam int CNT_W      = LEN_W + BYTE_IDX_W + 1;

    logic [LEN_W-1:0]      beat_cnt;
    logic [CNT_W-1:0]      bytes_sent;
    logic [BYTE_IDX_W-1:0] tail_bytes;

    // Bytes covered once the presented flit is taken.
    assign bytes_sent  = (CNT_W'(beat_cnt) + CNT_W'(1)) << BYTE_IDX_W;
    assign last_output = bytes_sent >= CNT_W'(payload_bytes);

    // Valid bytes in a partial last flit.
    assign tail_bytes = payload_bytes[BYTE_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (beat_taken) begin
            if (last_output) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Zero the bytes past the end of the message.
    always_comb begin
        data_flit = data;
        if (last_output && (tail_bytes != '0)) begin
            for (int i = 0; i < FLIT_BYTES; i++) begin
                if (i >= int'(tail_bytes)) begin
                    data_flit[i*8 +: 8] = 8'h00;
                end
            end
        end
    end

endmodule

//--- mrp_tx_noc_out_datap.sv
`timescale 1ns/1ps
`include "mrp_tx_cfg.svh"

module mrp_tx_noc_out_datap (
    input  logic                                clk,
    input  logic                                rst,
    input  mrp_tx_pkg::mrp_tx_meta              meta,
    input  logic                                store_inputs,
    input  mrp_tx_pkg::mrp_noc_out_flit_mux_sel flit_sel,
    input  logic [`MRP_NOC_FLIT_W-1:0]          data,
    input  logic                                data_val,
    input  logic                                data_rdy,
    output logic [`MRP_NOC_FLIT_W-1:0]          noc_flit,
    output logic                                last_output
);

    mrp_tx_pkg::mrp_noc_flit  hdr_flit;
    mrp_tx_pkg::mrp_noc_flit  meta_flit;
    mrp_tx_pkg::mrp_data_beat packed_beat;
    logic [`MRP_LEN_W-1:0]    payload_bytes;
    logic                     beat_taken;

    assign beat_taken = data_val & data_rdy;

    mrp_tx_hdr_build hdr_build (
        .clk           (clk),
        .rst           (rst),
        .meta          (meta),
        .store_inputs  (store_inputs),
        .hdr_flit      (hdr_flit),
        .meta_flit     (meta_flit),
        .payload_bytes (payload_bytes)
    );

    mrp_tx_data_pack data_pack (
        .clk           (clk),
        .rst           (rst),
        .data          (data),
        .beat_taken    (beat_taken),
        .payload_bytes (payload_bytes),
        .data_flit     (packed_beat.data),
        .last_output   (packed_beat.last)
    );

    assign last_output = packed_beat.last;

    always_comb begin
        case (flit_sel)
            mrp_tx_pkg::SEL_HDR_FLIT:  noc_flit = hdr_flit;
            mrp_tx_pkg::SEL_META_FLIT: noc_flit = meta_flit;
            default:                   noc_flit = packed_beat.data;
        endcase
    end

endmodule

//--- mrp_tx_noc_out_ctrl.sv
`timescale 1ns/1ps

module mrp_tx_noc_out_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    output logic                                noc_val,
    input  logic                                noc_rdy,
    input  logic                                meta_val,
    output logic                                meta_rdy,
    input  logic                                data_val,
    output logic                                data_rdy,
    output mrp_tx_pkg::mrp_noc_out_flit_mux_sel flit_sel,
    output logic                                store_inputs,
    input  logic                                last_output
);

    typedef enum logic [1:0] {
        READY         = 2'd0,
        META_FLIT_OUT = 2'd1,
        DATA_FLIT_OUT = 2'd2
    } state_e;

    state_e state_reg;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        noc_val      = 1'b0;
        meta_rdy     = 1'b0;
        data_rdy     = 1'b0;
        store_inputs = 1'b0;
        flit_sel     = mrp_tx_pkg::SEL_HDR_FLIT;
        state_next   = state_reg;

        case (state_reg)
            READY: begin
                // Header passes straight through from meta.
                noc_val  = meta_val;
                meta_rdy = noc_rdy;
                if (meta_val && noc_rdy) begin
                    store_inputs = 1'b1;
                    state_next   = META_FLIT_OUT;
                end
            end

            META_FLIT_OUT: begin
                noc_val  = 1'b1;
                flit_sel = mrp_tx_pkg::SEL_META_FLIT;
                if (noc_rdy) begin
                    state_next = DATA_FLIT_OUT;
                end
            end

            DATA_FLIT_OUT: begin
                noc_val  = data_val;
                data_rdy = noc_rdy;
                flit_sel = mrp_tx_pkg::SEL_DATA_FLIT;
                // Back to idle after the final payload flit.
                if (data_val && noc_rdy && last_output) begin
                    state_next = READY;
                end
            end

            default: begin
                state_next = READY;
            end
        endcase
    end

endmodule

//--- mrp_tx_noc_out.sv
`timescale 1ns/1ps
`include "mrp_tx_cfg.svh"

module mrp_tx_noc_out (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       meta_val,
    output logic                       meta_rdy,
    input  mrp_tx_pkg::mrp_tx_meta     meta,

    input  logic                       data_val,
    output logic                       data_rdy,
    input  logic [`MRP_NOC_FLIT_W-1:0] data,

    output logic                       noc_val,
    input  logic                       noc_rdy,
    output logic [`MRP_NOC_FLIT_W-1:0] noc_flit
);

    mrp_tx_pkg::mrp_noc_out_flit_mux_sel flit_sel;
    logic                                store_inputs;
    logic                                last_output;

    mrp_tx_noc_out_ctrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .noc_val      (noc_val),
        .noc_rdy      (noc_rdy),
        .meta_val     (meta_val),
        .meta_rdy     (meta_rdy),
        .data_val     (data_val),
        .data_rdy     (data_rdy),
        .flit_sel     (flit_sel),
        .store_inputs (store_inputs),
        .last_output  (last_output)
    );

    // data_rdy also qualifies the payload beat count.
    mrp_tx_noc_out_datap datap (
        .clk          (clk),
        .rst          (rst),
        .meta         (meta),
        .store_inputs (store_inputs),
        .flit_sel     (flit_sel),
        .data         (data),
        .data_val     (data_val),
        .data_rdy     (data_rdy),
        .noc_flit     (noc_flit),
        .last_output  (last_output)
    );

endmodule

//--- tb_mrp_tx_noc_out.sv
`timescale 1ns/1ps
`include "mrp_tx_cfg.svh"

module tb_mrp_tx_noc_out;

    localparam int NUM_MSGS = 8;

    typedef struct packed {
        mrp_tx_pkg::mrp_tx_meta     meta;
        logic [`MRP_NOC_FLIT_W-1:0] seed;
        logic [`MRP_LEN_W-1:0]      exp_flits;
    } msg_entry;

    // Each row holds the metadata, the payload seed and the header flit count.
    msg_entry tbl [NUM_MSGS] = '{
        '{'{8'h01, 8'h02, 16'h1001, 16'h2001, 16'h0a01, 16'd1,  32'h0000_0011},
          64'h8877_6655_4433_2211, 16'd2},
        '{'{8'h03, 8'h04, 16'h1002, 16'h2002, 16'h0a02, 16'd8,  32'h0000_0022},
          64'hf1e2_d3c4_b5a6_9788, 16'd2},
        '{'{8'h05, 8'h06, 16'h1003, 16'h2003, 16'h0a03, 16'd9,  32'h0000_0033},
          64'h1357_9bdf_2468_ace0, 16'd3},
        '{'{8'h07, 8'h08, 16'h1004, 16'h2004, 16'h0a04, 16'd15, 32'h0000_0044},
          64'hdead_beef_cafe_f00d, 16'd3},
        '{'{8'h09, 8'h0a, 16'h1005, 16'h2005, 16'h0a05, 16'd64, 32'h0000_0055},
          64'h0f1e_2d3c_4b5a_6978, 16'd9},
        '{'{8'h0b, 8'h0c, 16'h1006, 16'h2006, 16'h0a06, 16'd3,  32'h0000_0066},
          64'h5a5a_a5a5_3c3c_c3c3, 16'd2},
        '{'{8'h0d, 8'h0e, 16'h1007, 16'h2007, 16'h0a07, 16'd17, 32'h0000_0077},
          64'h0123_4567_89ab_cdef, 16'd4},
        '{'{8'h0f, 8'h10, 16'h1008, 16'h2008, 16'h0a08, 16'd40, 32'h0000_0088},
          64'h7766_5544_3322_1100, 16'd6}
    };

    logic                       clk;
    logic                       rst;
    logic                       meta_val;
    logic                       meta_rdy;
    mrp_tx_pkg::mrp_tx_meta     meta;
    logic                       data_val;
    logic                       data_rdy;
    logic [`MRP_NOC_FLIT_W-1:0] data;
    logic                       noc_val;
    logic                       noc_rdy;
    logic [`MRP_NOC_FLIT_W-1:0] noc_flit;

    mrp_tx_pkg::mrp_noc_flit exp_q[$];
    int                      kind_q[$];
    bit                      stall;
    bit                      gap_check;
    bit                      have_prev;
    int                      prev_cycle;
    int                      cycle_cnt;
    int                      limit_cycles;
    int                      total_flits;

    mrp_tx_noc_out dut (
        .clk      (clk),
        .rst      (rst),
        .meta_val (meta_val),
        .meta_rdy (meta_rdy),
        .meta     (meta),
        .data_val (data_val),
        .data_rdy (data_rdy),
        .data     (data),
        .noc_val  (noc_val),
        .noc_rdy  (noc_rdy),
        .noc_flit (noc_flit)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        noc_rdy = !stall || (($urandom % 3) != 0);
    endtask

    // Reference flit stream of one message.
    task automatic queue_expected(input int idx);
        mrp_tx_pkg::mrp_noc_flit    f;
        logic [`MRP_NOC_FLIT_W-1:0] w;
        int                         nbeats;
        int                         tail;
        nbeats = int'(tbl[idx].exp_flits) - 1;
        tail = int'(tbl[idx].meta.payload_bytes) % 8;
        f = '0;
        f.hdr.dst_x      = tbl[idx].meta.dst_x;
        f.hdr.dst_y      = tbl[idx].meta.dst_y;
        f.hdr.flit_count = tbl[idx].exp_flits;
        f.hdr.msg_type   = `MRP_MSG_TYPE;
        exp_q.push_back(f);
        kind_q.push_back(0);
        f = '0;
        f.meta.src_port      = tbl[idx].meta.src_port;
        f.meta.dst_port      = tbl[idx].meta.dst_port;
        f.meta.conn_id       = tbl[idx].meta.conn_id;
        f.meta.payload_bytes = tbl[idx].meta.payload_bytes;
        exp_q.push_back(f);
        kind_q.push_back(1);
        for (int k = 0; k < nbeats; k++) begin
            w = tbl[idx].seed + 64'(k);
            if (k == nbeats - 1 && tail != 0) begin
                for (int b = tail; b < 8; b++) begin
                    w[b*8 +: 8] = 8'h00;
                end
            end
            exp_q.push_back(mrp_tx_pkg::mrp_noc_flit'(w));
            kind_q.push_back(2);
        end
    endtask

    task automatic send_msg(input int idx);
        int nbeats;
        int k;
        bit taken;
        nbeats = int'(tbl[idx].exp_flits) - 1;
        next_cycle();
        data_val = 1'b0;
        meta = tbl[idx].meta;
        meta_val = 1'b1;
        #1;
        while (!meta_rdy) begin
            next_cycle();
            #1;
        end
        k = 0;
        taken = 1'b1;
        while (k < nbeats) begin
            next_cycle();
            // Stored copy must not follow the live bus.
            meta_val = 1'b0;
            meta = ~tbl[idx].meta;
            if (taken || !data_val) begin
                data = tbl[idx].seed + 64'(k);
                data_val = !stall || (($urandom % 3) != 0);
            end
            #1;
            taken = data_val && data_rdy;
            if (taken) begin
                k++;
            end
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        mrp_tx_pkg::mrp_noc_flit got;
        mrp_tx_pkg::mrp_noc_flit exp;
        int                      kind;
        cycle_cnt++;
        if (cycle_cnt >= limit_cycles) begin
            $display("ERROR: timeout after %0d cycles, %0d flits never arrived",
                     cycle_cnt, exp_q.size());
            abort_run();
        end else if (!rst && noc_val && noc_rdy) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: flit 0x%h arrived when none was expected", noc_flit);
                abort_run();
            end else begin
                got = noc_flit;
                exp = exp_q.pop_front();
                kind = kind_q.pop_front();
                if (kind == 0) begin
                    check_value("hdr.dst_x", 64'(got.hdr.dst_x), 64'(exp.hdr.dst_x));
                    check_value("hdr.dst_y", 64'(got.hdr.dst_y), 64'(exp.hdr.dst_y));
                    check_value("hdr.flit_count", 64'(got.hdr.flit_count),
                                64'(exp.hdr.flit_count));
                    check_value("hdr.msg_type", 64'(got.hdr.msg_type), 64'(exp.hdr.msg_type));
                    check_value("hdr.pad", 64'(got.hdr.pad), 64'(exp.hdr.pad));
                end else if (kind == 1) begin
                    check_value("meta.src_port", 64'(got.meta.src_port),
                                64'(exp.meta.src_port));
                    check_value("meta.dst_port", 64'(got.meta.dst_port),
                                64'(exp.meta.dst_port));
                    check_value("meta.conn_id", 64'(got.meta.conn_id), 64'(exp.meta.conn_id));
                    check_value("meta.payload_bytes", 64'(got.meta.payload_bytes),
                                64'(exp.meta.payload_bytes));
                end else begin
                    check_value("noc_flit", got, exp);
                end
                // Without stalls every cycle carries a flit.
                if (gap_check && have_prev) begin
                    check_value("flit spacing in cycles", 64'(cycle_cnt - prev_cycle), 64'd1);
                end
                have_prev = 1'b1;
                prev_cycle = cycle_cnt;
            end
        end
    end

    initial begin
        void'($urandom(45));
        clk = 1'b0;
        rst = 1'b1;
        meta_val = 1'b0;
        meta = '0;
        data_val = 1'b0;
        data = '0;
        noc_rdy = 1'b1;
        stall = 1'b0;
        gap_check = 1'b0;
        have_prev = 1'b0;
        prev_cycle = 0;
        cycle_cnt = 0;
        total_flits = 0;
        for (int i = 0; i < NUM_MSGS; i++) begin
            total_flits += 1 + int'(tbl[i].exp_flits);
        end
        // Both passes send the whole table.
        total_flits = 2 * total_flits;
        limit_cycles = 4 * total_flits + 200;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle with no meta offered.
        repeat (3) begin
            @(negedge clk);
            #1;
            check_value("noc_val", 64'(noc_val), 64'd0);
            check_value("meta_rdy", 64'(meta_rdy), 64'd1);
            check_value("data_rdy", 64'(data_rdy), 64'd0);
        end

        gap_check = 1'b1;
        for (int i = 0; i < NUM_MSGS; i++) begin
            queue_expected(i);
            send_msg(i);
        end
        drain();
        gap_check = 1'b0;

        stall = 1'b1;
        for (int i = 0; i < NUM_MSGS; i++) begin
            queue_expected(i);
            send_msg(i);
        end
        drain();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
mrp_tx_pkg.sv
mrp_tx_hdr_build.sv
mrp_tx_data_pack.sv
mrp_tx_noc_out_datap.sv
mrp_tx_noc_out_ctrl.sv
mrp_tx_noc_out.sv
tb_mrp_tx_noc_out.sv

//--- run.sh
#!/bin/sh
# Build and run the MRP transmit output stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

top=tb_mrp_tx_noc_out
log=sim.log

verilator --binary --timing -j 0 --top-module "$top" -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "^Simulation finished: PASS$" "$log"
status=$?
if [ $status -ne 0 ]; then
    echo "Pass message not found in $log"
    exit 1
fi

exit 0
